// File: design/pack_macros.svh
// frame packer constants for sync, tail, CRC and APB register map
`ifndef PACK_MACROS_SVH
`define PACK_MACROS_SVH

// head sync pattern
`define PACK_SYNC0 8'hA5
`define PACK_SYNC1 8'h5A

// tail pattern
`define PACK_TAIL0 8'hC3
`define PACK_TAIL1 8'h3C

// CRC-8 from init 0x00 and MSB first
`define PACK_CRC_POLY 8'h07

// APB register offsets
`define PACK_REG_CTRL 8'h00
`define PACK_REG_LEN  8'h04
`define PACK_REG_CNT  8'h08

`endif

// File: design/pack_frame_pkg.sv
// frame packer stream-side types for bytes, seconds, sequencer states and beats
`default_nettype none

package pack_frame_pkg;

	typedef logic [7:0]  byte_t;  // one stream byte.
	typedef logic [31:0] sec_t;   // utc seconds.
	typedef logic [7:0]  seq_t;   // frame sequence number.

	// sequencer states in 4-bit codes
	typedef enum logic [3:0] {
		st_idle      = 4'h0,
		st_fire_head = 4'h1,
		st_wait_head = 4'h2,
		st_fire_load = 4'h3,
		st_wait_load = 4'h4,
		st_fire_tail = 4'h5,
		st_wait_tail = 4'h6,
		st_fire_crc  = 4'hc,
		st_wait_crc  = 4'hd,
		st_done      = 4'hf
	} pack_state_e;

	typedef struct packed {
		byte_t data;  // stream byte.
		logic  last;  // set on crc byte only.
	} beat_t;

endpackage

`default_nettype wire

// File: design/pack_cfg_pkg.sv
// frame packer configuration types for APB request, response and config word
`default_nettype none

package pack_cfg_pkg;
	import pack_frame_pkg::*;

	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic  pack_en;   // ctrl bit 0.
		byte_t load_len;  // payload bytes per frame.
	} pack_cfg_t;

endpackage

`default_nettype wire

// File: design/pack_cfg_regs.sv
// APB register block for packer enable, payload length and frame count
`timescale 1ns/1ps
`default_nettype none
`include "pack_macros.svh"

module pack_cfg_regs import pack_cfg_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      rst_n,
	input  wire apb_req_t  apb_req,
	input  wire logic      frame_done,
	output      apb_rsp_t  apb_rsp,
	output      pack_cfg_t cfg
);

	pack_cfg_t   cfg_q;
	logic [15:0] frm_cnt_q;
	logic        pslverr_q;
	apb_data_t   prdata_q;
	apb_data_t   rd_data;
	logic        acc_err;
	logic        setup;
	logic        wr_en;

	assign setup = apb_req.psel & ~apb_req.penable;
	assign wr_en = apb_req.psel & apb_req.penable & apb_req.pwrite;

	// ######################################################################
	// address decode
	always_comb begin
		rd_data = '0;
		acc_err = 1'b0;
		case (apb_req.paddr)
			`PACK_REG_CTRL: rd_data = {31'd0, cfg_q.pack_en};
			`PACK_REG_LEN:  rd_data = {24'd0, cfg_q.load_len};
			`PACK_REG_CNT: begin
				rd_data = {16'd0, frm_cnt_q};
				acc_err = apb_req.pwrite;  // read only.
			end
			default:        acc_err = 1'b1;
		endcase
		if (acc_err)
			rd_data = '0;
	end

	// ######################################################################
	// registers
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q     <= '0;
			frm_cnt_q <= '0;
			pslverr_q <= 1'b0;
		end else begin
			pslverr_q <= setup & acc_err;  // shown in access phase.
			if (wr_en && apb_req.paddr == `PACK_REG_CTRL)
				cfg_q.pack_en <= apb_req.pwdata[0];
			if (wr_en && apb_req.paddr == `PACK_REG_LEN)
				cfg_q.load_len <= apb_req.pwdata[7:0];
			if (frame_done)
				frm_cnt_q <= frm_cnt_q + 16'd1;  // wraps.
		end
	end

	// read data captured in setup and held for access.
	always_ff @(posedge clk_sys) begin
		if (setup)
			prdata_q <= rd_data;
	end

	assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};
	assign cfg     = cfg_q;

endmodule

`default_nettype wire

// File: design/pack_main.sv
// frame sequencer firing head, payload, tail and CRC on each seconds change
`timescale 1ns/1ps
`default_nettype none

module pack_main import pack_frame_pkg::*, pack_cfg_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      rst_n,
	input  wire pack_cfg_t cfg,
	input  wire sec_t      utc_sec,
	input  wire logic      done_head,
	input  wire logic      done_load,
	input  wire logic      done_tail,
	input  wire logic      done_crc,
	output      logic      fire_head,
	output      logic      fire_load,
	output      logic      fire_tail,
	output      logic      fire_crc,
	output      seq_t      seq,
	output      logic      pk_frm,
	output      logic      frame_done
);

	pack_state_e st_q;
	sec_t        utc_sec_q;
	seq_t        seq_q;
	logic        sec_chg;

	assign sec_chg = (utc_sec != utc_sec_q);

	// ######################################################################
	// main FSM
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			st_q <= st_idle;
		end else begin
			case (st_q)
				st_idle:      st_q <= (cfg.pack_en && sec_chg) ? st_fire_head : st_idle;
				st_fire_head: st_q <= st_wait_head;
				st_wait_head: st_q <= done_head ? st_fire_load : st_wait_head;
				st_fire_load: st_q <= st_wait_load;
				st_wait_load: st_q <= done_load ? st_fire_tail : st_wait_load;
				st_fire_tail: st_q <= st_wait_tail;
				st_wait_tail: st_q <= done_tail ? st_fire_crc : st_wait_tail;
				st_fire_crc:  st_q <= st_wait_crc;
				st_wait_crc:  st_q <= done_crc ? st_done : st_wait_crc;
				st_done:      st_q <= st_idle;
				default:      st_q <= st_idle;
			endcase
		end
	end

	// seconds copy for change detect, sequence number.
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			utc_sec_q <= '0;
			seq_q     <= '0;
		end else begin
			utc_sec_q <= utc_sec;
			if (st_q == st_done)
				seq_q <= seq_q + 8'd1;
		end
	end

	assign fire_head  = (st_q == st_fire_head);
	assign fire_load  = (st_q == st_fire_load);
	assign fire_tail  = (st_q == st_fire_tail);
	assign fire_crc   = (st_q == st_fire_crc);
	assign frame_done = (st_q == st_done);
	assign pk_frm     = (st_q != st_idle);  // frame in progress.
	assign seq        = seq_q;

endmodule

`default_nettype wire

// File: design/pack_wrap_gen.sv
// head and tail byte generator stepping through sync, seconds, seq and length
`timescale 1ns/1ps
`default_nettype none
`include "pack_macros.svh"

module pack_wrap_gen import pack_frame_pkg::*; (
	input  wire logic  clk_sys,
	input  wire logic  rst_n,
	input  wire logic  fire_head,
	input  wire logic  fire_tail,
	input  wire sec_t  utc_sec,
	input  wire seq_t  seq,
	input  wire byte_t load_len,
	input  wire logic  ready,
	output      logic  valid,
	output      beat_t beat,
	output      logic  done_head,
	output      logic  done_tail
);

	logic       active_q;
	logic       head_q;   // 1 = head, 0 = tail.
	logic [2:0] idx_q;
	sec_t       sec_q;
	seq_t       seq_q;
	byte_t      len_q;
	byte_t      data;
	logic       seg_end;

	assign seg_end = active_q & ready & (idx_q == (head_q ? 3'd7 : 3'd1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			head_q   <= 1'b0;
			idx_q    <= '0;
		end else if (fire_head || fire_tail) begin
			active_q <= 1'b1;
			head_q   <= fire_head;
			idx_q    <= '0;
		end else if (seg_end) begin
			active_q <= 1'b0;
		end else if (active_q && ready) begin
			idx_q <= idx_q + 3'd1;  // next byte.
		end
	end

	// frame values for the head.
	always_ff @(posedge clk_sys) begin
		if (fire_head) begin
			sec_q <= utc_sec;
			seq_q <= seq;
			len_q <= load_len;
		end
	end

	always_comb begin
		case (idx_q)
			3'd0:    data = head_q ? `PACK_SYNC0 : `PACK_TAIL0;
			3'd1:    data = head_q ? `PACK_SYNC1 : `PACK_TAIL1;
			3'd2:    data = sec_q[31:24];  // seconds from the high byte.
			3'd3:    data = sec_q[23:16];
			3'd4:    data = sec_q[15:8];
			3'd5:    data = sec_q[7:0];
			3'd6:    data = seq_q;
			default: data = len_q;
		endcase
	end

	assign valid     = active_q;
	assign beat      = '{data: data, last: 1'b0};
	assign done_head = seg_end & head_q;
	assign done_tail = seg_end & ~head_q;

endmodule

`default_nettype wire

// File: design/pack_load_gen.sv
// payload generator emitting an incrementing byte run seeded by the sequence
`timescale 1ns/1ps
`default_nettype none

module pack_load_gen import pack_frame_pkg::*, pack_cfg_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      rst_n,
	input  wire logic      fire_load,
	input  wire pack_cfg_t cfg,
	input  wire seq_t      seq,
	input  wire logic      ready,
	output      logic      valid,
	output      beat_t     beat,
	output      logic      done_load
);

	logic  active_q;
	logic  zero_q;    // empty payload gives done next cycle.
	byte_t rem_q;
	byte_t data_q;
	logic  last_xfer;

	assign last_xfer = active_q & ready & (rem_q == 8'd1);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			zero_q   <= 1'b0;
			rem_q    <= '0;
		end else begin
			zero_q <= fire_load & (cfg.load_len == 8'd0);
			if (fire_load) begin
				active_q <= (cfg.load_len != 8'd0);
				rem_q    <= cfg.load_len;
			end else if (active_q && ready) begin
				active_q <= ~last_xfer;
				rem_q    <= rem_q - 8'd1;
			end
		end
	end

	// byte i = seq + i.
	always_ff @(posedge clk_sys) begin
		if (fire_load)
			data_q <= seq;
		else if (active_q && ready)
			data_q <= data_q + 8'd1;
	end

	assign valid     = active_q;
	assign beat      = '{data: data_q, last: 1'b0};
	assign done_load = zero_q | last_xfer;

endmodule

`default_nettype wire

// File: design/pack_crc_mux.sv
// output merger that steers ready to the active source and appends the CRC-8 byte
`timescale 1ns/1ps
`default_nettype none
`include "pack_macros.svh"

module pack_crc_mux import pack_frame_pkg::*; (
	input  wire logic  clk_sys,
	input  wire logic  rst_n,
	input  wire logic  fire_head,
	input  wire logic  fire_crc,
	input  wire logic  wrap_valid,
	input  wire beat_t wrap_beat,
	input  wire logic  load_valid,
	input  wire beat_t load_beat,
	input  wire logic  out_ready,
	output      logic  wrap_ready,
	output      logic  load_ready,
	output      logic  out_valid,
	output      beat_t out_beat,
	output      logic  done_crc
);

	byte_t crc_q;
	logic  crc_active_q;
	logic  xfer;

	// one CRC-8 step over a whole byte taken msb first
	function automatic byte_t crc8_byte(input byte_t crc, input byte_t data);
		byte_t c;
		c = crc ^ data;
		for (int i = 0; i < 8; i++)
			c = c[7] ? ((c << 1) ^ `PACK_CRC_POLY) : (c << 1);
		return c;
	endfunction

	// ######################################################################
	// source select with only one source active at a time
	always_comb begin
		if (crc_active_q)
			out_beat = '{data: crc_q, last: 1'b1};
		else if (load_valid)
			out_beat = load_beat;
		else
			out_beat = wrap_beat;
	end

	assign out_valid  = wrap_valid | load_valid | crc_active_q;
	assign load_ready = out_ready & ~crc_active_q;
	assign wrap_ready = out_ready & ~crc_active_q & ~load_valid;
	assign xfer       = out_valid & out_ready;
	assign done_crc   = crc_active_q & out_ready;

	// ######################################################################
	// running CRC and the closing byte
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			crc_q        <= '0;
			crc_active_q <= 1'b0;
		end else begin
			if (fire_head)
				crc_q <= '0;  // new frame.
			else if (xfer && !crc_active_q)
				crc_q <= crc8_byte(crc_q, out_beat.data);
			if (fire_crc)
				crc_active_q <= 1'b1;
			else if (done_crc)
				crc_active_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/pack_top.sv
// frame packer top joining register block, sequencer, generators and merger
`timescale 1ns/1ps
`default_nettype none

module pack_top import pack_frame_pkg::*, pack_cfg_pkg::*; (
	input  wire logic     clk_sys,
	input  wire logic     rst_n,
	input  wire apb_req_t apb_req,
	input  wire sec_t     utc_sec,
	input  wire logic     out_ready,
	output      apb_rsp_t apb_rsp,
	output      logic     out_valid,
	output      beat_t    out_beat,
	output      logic     pk_frm
);

	pack_cfg_t cfg;
	seq_t      seq;
	logic      frame_done;
	logic      fire_head, fire_load, fire_tail, fire_crc;
	logic      done_head, done_load, done_tail, done_crc;
	logic      wrap_valid, wrap_ready;
	logic      load_valid, load_ready;
	beat_t     wrap_beat, load_beat;

	pack_cfg_regs regs0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .apb_req(apb_req),
		.frame_done(frame_done), .apb_rsp(apb_rsp), .cfg(cfg)
	);

	pack_main main0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .cfg(cfg), .utc_sec(utc_sec),
		.done_head(done_head), .done_load(done_load),
		.done_tail(done_tail), .done_crc(done_crc),
		.fire_head(fire_head), .fire_load(fire_load),
		.fire_tail(fire_tail), .fire_crc(fire_crc),
		.seq(seq), .pk_frm(pk_frm), .frame_done(frame_done)
	);

	pack_wrap_gen wrap0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .fire_head(fire_head),
		.fire_tail(fire_tail), .utc_sec(utc_sec), .seq(seq),
		.load_len(cfg.load_len), .ready(wrap_ready), .valid(wrap_valid),
		.beat(wrap_beat), .done_head(done_head), .done_tail(done_tail)
	);

	pack_load_gen load0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .fire_load(fire_load), .cfg(cfg),
		.seq(seq), .ready(load_ready), .valid(load_valid), .beat(load_beat),
		.done_load(done_load)
	);

	pack_crc_mux crc0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .fire_head(fire_head),
		.fire_crc(fire_crc), .wrap_valid(wrap_valid), .wrap_beat(wrap_beat),
		.load_valid(load_valid), .load_beat(load_beat), .out_ready(out_ready),
		.wrap_ready(wrap_ready), .load_ready(load_ready),
		.out_valid(out_valid), .out_beat(out_beat), .done_crc(done_crc)
	);

endmodule

`default_nettype wire

// File: bench/pack_tb.sv
// testbench for the frame packer with random APB and seconds stimulus against a frame model
`timescale 1ns/1ps
`default_nettype none
`include "pack_macros.svh"

module pack_tb import pack_frame_pkg::*, pack_cfg_pkg::*; ();

	localparam int clk_period       = 40;
	localparam int frames_per_phase = 12;
	localparam int frame_limit      = 8 * (8 + 40 + 2 + 1) + 5;  // worst case under random ready.
	localparam int timeout_cyc      = 2 * frames_per_phase * (frame_limit + 20) + 200;

	logic     clk_sys;
	logic     rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	sec_t     utc_sec;
	logic     out_ready;
	logic     out_valid;
	beat_t    out_beat;
	logic     pk_frm;

	integer     seed;
	integer     ready_seed;  // own stream for out_ready.
	logic [31:0] ready_rnd;
	int         err_cnt;
	int         frames_exp;
	seq_t       seq_exp;
	sec_t       cur_sec;
	logic       rand_ready;
	logic [8:0] exp_q[$];  // {data, last} per beat.
	logic       held_valid;
	logic [8:0] held_beat;
	logic [8:0] exp_beat;
	apb_data_t  rd;
	logic       err;

	pack_top dut0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .apb_req(apb_req), .utc_sec(utc_sec),
		.out_ready(out_ready), .apb_rsp(apb_rsp), .out_valid(out_valid),
		.out_beat(out_beat), .pk_frm(pk_frm)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	// CRC-8 taken one bit per step.
	function automatic byte_t crc8_step(input byte_t crc, input byte_t data);
		byte_t c;
		logic  fb;
		int    b;
		c = crc;
		for (b = 7; b >= 0; b--) begin
			fb = c[7] ^ data[b];
			c  = {c[6:0], 1'b0};
			if (fb)
				c = c ^ `PACK_CRC_POLY;
		end
		return c;
	endfunction

	// ######################################################################
	// APB access
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic perr);
		@(negedge clk_sys);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge clk_sys);
		apb_req.penable = 1'b1;
		check_value("apb_rsp.pready", 1, apb_rsp.pready);
		perr = apb_rsp.pslverr;
		@(negedge clk_sys);
		apb_req = '0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic perr);
		@(negedge clk_sys);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(negedge clk_sys);
		apb_req.penable = 1'b1;
		check_value("apb_rsp.pready", 1, apb_rsp.pready);
		data = apb_rsp.prdata;
		perr = apb_rsp.pslverr;
		@(negedge clk_sys);
		apb_req = '0;
	endtask

	// ######################################################################
	// frame model
	task automatic build_frame(input sec_t sec, input seq_t sq, input byte_t len);
		byte_t bytes[$];
		byte_t crc;
		byte_t val;
		int    i;
		bytes = '{`PACK_SYNC0, `PACK_SYNC1, sec[31:24], sec[23:16],
			sec[15:8], sec[7:0], sq, len};
		val = sq;
		for (i = 0; i < len; i++) begin
			bytes.push_back(val);
			val = val + 8'd1;  // payload counts up from seq.
		end
		bytes.push_back(`PACK_TAIL0);
		bytes.push_back(`PACK_TAIL1);
		crc = 8'h00;
		foreach (bytes[k]) begin
			crc = crc8_step(crc, bytes[k]);
			exp_q.push_back({bytes[k], 1'b0});
		end
		exp_q.push_back({crc, 1'b1});
	endtask

	task automatic wait_frame_end();
		int cyc;
		cyc = 0;
		while (pk_frm && cyc < frame_limit) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (pk_frm) begin
			err_cnt++;
			$display("error at %0t ns: frame still running after %0d cycles", $time, cyc);
		end
	endtask

	task automatic send_frame();
		apb_data_t len;
		logic      perr;
		int        gap;
		len = $unsigned($random(seed)) % 41;
		apb_write(`PACK_REG_LEN, len, perr);
		check_value("apb_rsp.pslverr", 0, perr);
		cur_sec = cur_sec + 1 + ($unsigned($random(seed)) % 1000);
		build_frame(cur_sec, seq_exp, len[7:0]);
		utc_sec = cur_sec;
		@(negedge clk_sys);
		check_value("pk_frm", 1, pk_frm);
		gap = 1 + ($unsigned($random(seed)) % 8);
		repeat (gap) @(negedge clk_sys);
		// a change mid-frame must be ignored.
		if (pk_frm && $random(seed) & 1) begin
			cur_sec = cur_sec + 5;
			utc_sec = cur_sec;
		end
		wait_frame_end();
		seq_exp = seq_exp + 8'd1;
		frames_exp++;
	endtask

	task automatic idle_seconds(input int changes);
		int n;
		int c;
		for (n = 0; n < changes; n++) begin
			@(negedge clk_sys);
			cur_sec = cur_sec + 3;
			utc_sec = cur_sec;
			for (c = 0; c < 6; c++) begin
				@(negedge clk_sys);
				check_value("pk_frm", 0, pk_frm);
				check_value("out_valid", 0, out_valid);
			end
		end
	endtask

	// ######################################################################
	// ready driver and stream monitor, a beat moves at the next rising edge
	always @(negedge clk_sys) begin
		ready_rnd = $random(ready_seed);
		out_ready = rand_ready ? ready_rnd[0] : 1'b1;
		if (rst_n) begin
			if (held_valid) begin
				check_value("out_valid stalled", 1, out_valid);
				check_value("out_beat stalled", held_beat, out_beat);
			end
			held_valid = out_valid && !out_ready;
			held_beat  = out_beat;
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("error at %0t ns: beat sent with no frame expected", $time);
				end else begin
					exp_beat = exp_q.pop_front();
					check_value("out_beat.data", exp_beat[8:1], out_beat.data);
					check_value("out_beat.last", exp_beat[0], out_beat.last);
				end
			end
		end
	end

	initial begin
		#(timeout_cyc * clk_period);
		$display("watchdog: run did not finish within %0d cycles, errors: %0d",
			timeout_cyc, err_cnt);
		$display("Finished with errors");
		$finish;
	end

	// ######################################################################
	// test sequence
	initial begin
		seed       = 33982;
		ready_seed = seed + 1;
		err_cnt    = 0;
		frames_exp = 0;
		seq_exp    = '0;
		cur_sec    = '0;
		rand_ready = 1'b0;
		held_valid = 1'b0;
		apb_req    = '0;
		utc_sec    = '0;
		out_ready  = 1'b1;
		rst_n      = 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		apb_read(`PACK_REG_CTRL, rd, err);
		check_value("ctrl", 0, rd);
		check_value("apb_rsp.pslverr", 0, err);
		apb_read(`PACK_REG_LEN, rd, err);
		check_value("len", 0, rd);
		apb_read(`PACK_REG_CNT, rd, err);
		check_value("cnt", 0, rd);
		apb_read(8'h0c, rd, err);  // unmapped.
		check_value("apb_rsp.pslverr", 1, err);
		check_value("apb_rsp.prdata", 0, rd);
		apb_write(`PACK_REG_CNT, 32'h5, err);
		check_value("apb_rsp.pslverr", 1, err);

		idle_seconds(4);  // packer still disabled.
		apb_write(`PACK_REG_CTRL, 32'h1, err);
		repeat (frames_per_phase) send_frame();
		@(posedge clk_sys);
		rand_ready = 1'b1;
		repeat (frames_per_phase) send_frame();
		@(posedge clk_sys);
		rand_ready = 1'b0;

		apb_read(`PACK_REG_CNT, rd, err);
		check_value("cnt", frames_exp, rd);
		check_value("beats left", 0, exp_q.size());

		$display("errors: %0d, frames: %0d", err_cnt, frames_exp);
		if (err_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/pack_frame_pkg.sv
design/pack_cfg_pkg.sv
design/pack_cfg_regs.sv
design/pack_main.sv
design/pack_wrap_gen.sv
design/pack_load_gen.sv
design/pack_crc_mux.sv
design/pack_top.sv
bench/pack_tb.sv
